// ==== Bender.yml ====
package:
  name: pokey_ports

sources:
  - files:
      - logic/pokey_cfg_pkg.sv
      - logic/pokey_state_pkg.sv
      - logic/scan_timebase.sv
      - logic/key_scanner.sv
      - logic/pot_scanner.sv
      - logic/trigger_latch.sv
      - logic/pokey_ports_top.sv
  - target: test
    files:
      - verification/pokey_ports_checker.sv
      - verification/pokey_ports_tb.sv

// ==== logic/key_scanner.sv ====
`timescale 1ns/1ns

module key_scanner (
    input  logic                                 clk_27mhz_fpga,
    input  logic                                 rst,
    input  logic                                 o2_tick,
    input  logic [pokey_cfg_pkg::KEY_COLS-1:0]   key_col_l,
    output logic [pokey_cfg_pkg::KEY_ROWS-1:0]   key_row_l,
    output logic [pokey_cfg_pkg::KEY_CODE_W-1:0] kbcode,
    output logic                                 key_depr
);

    pokey_state_pkg::key_state_e state;

    // columns come straight off the keypad
    logic [pokey_cfg_pkg::KEY_COLS-1:0] col_meta;
    logic [pokey_cfg_pkg::KEY_COLS-1:0] col_sync;

    logic [pokey_cfg_pkg::KEY_ROW_W-1:0] row_idx;
    logic                                last_row;
    logic                                scan_end;

    // key seen on the row being strobed now
    logic                                 row_hit;
    logic [pokey_cfg_pkg::KEY_COL_W-1:0]  row_col;
    logic [pokey_cfg_pkg::KEY_CODE_W-1:0] row_code;

    // result so far for the scan in progress
    logic                                 scan_hit;
    logic [pokey_cfg_pkg::KEY_CODE_W-1:0] scan_code;
    logic                                 cur_hit;
    logic [pokey_cfg_pkg::KEY_CODE_W-1:0] cur_code;

    // compare latch, code from the scan before
    logic [pokey_cfg_pkg::KEY_CODE_W-1:0] prev_code;
    logic                                 empty_seen;

    always_ff @(posedge clk_27mhz_fpga) begin
        col_meta <= key_col_l;
        col_sync <= col_meta;
    end

    assign last_row = (row_idx == pokey_cfg_pkg::KEY_ROW_W'(pokey_cfg_pkg::KEY_ROWS - 1));
    assign scan_end = o2_tick && last_row;

    // one row per o2 tick
    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            row_idx <= '0;
        end else if (o2_tick) begin
            row_idx <= last_row ? '0 : row_idx + 1'b1;
        end
    end

    // single low bit walks across the rows
    assign key_row_l = ~({{(pokey_cfg_pkg::KEY_ROWS - 1){1'b0}}, 1'b1} << row_idx);

    assign row_hit = ~&col_sync;

    // lowest pressed column wins
    always_comb begin
        row_col = '0;
        for (int c = pokey_cfg_pkg::KEY_COLS - 1; c >= 0; c--) begin
            if (!col_sync[c]) begin
                row_col = pokey_cfg_pkg::KEY_COL_W'(c);
            end
        end
    end

    assign row_code = pokey_cfg_pkg::KEY_CODE_W'(row_idx * pokey_cfg_pkg::KEY_COLS + row_col);

    // first key found in a scan is the one that counts
    assign cur_hit  = scan_hit | row_hit;
    assign cur_code = scan_hit ? scan_code : row_code;

    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            scan_hit <= 1'b0;
        end else if (o2_tick) begin
            scan_hit <= last_row ? 1'b0 : cur_hit;
        end
    end

    always_ff @(posedge clk_27mhz_fpga) begin
        if (o2_tick) begin
            scan_code <= cur_code;
        end
        if (scan_end) begin
            prev_code <= cur_code;
        end
    end

    // sequencer steps once per full scan
    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            state      <= pokey_state_pkg::KEY_IDLE;
            kbcode     <= '0;
            key_depr   <= 1'b0;
            empty_seen <= 1'b0;
        end else if (scan_end) begin
            case (state)
                pokey_state_pkg::KEY_IDLE: begin
                    if (cur_hit) begin
                        state <= pokey_state_pkg::KEY_CONFIRM;
                    end
                end
                pokey_state_pkg::KEY_CONFIRM: begin
                    if (!cur_hit) begin
                        state <= pokey_state_pkg::KEY_IDLE;
                    end else if (cur_code == prev_code) begin
                        // two scans agree
                        state      <= pokey_state_pkg::KEY_HELD;
                        kbcode     <= cur_code;
                        key_depr   <= 1'b1;
                        empty_seen <= 1'b0;
                    end
                end
                pokey_state_pkg::KEY_HELD: begin
                    if (cur_hit && (cur_code == kbcode)) begin
                        key_depr   <= 1'b1;
                        empty_seen <= 1'b0;
                    end else if (cur_hit) begin
                        // another key, needs its own confirm
                        state    <= pokey_state_pkg::KEY_CONFIRM;
                        key_depr <= 1'b0;
                    end else if (empty_seen) begin
                        state <= pokey_state_pkg::KEY_IDLE;
                    end else begin
                        // depressed flag drops on the first empty scan
                        empty_seen <= 1'b1;
                        key_depr   <= 1'b0;
                    end
                end
                default: begin
                    state <= pokey_state_pkg::KEY_IDLE;
                end
            endcase
        end
    end

    a_row_onehot: assert property (@(posedge clk_27mhz_fpga) disable iff (rst)
        $onehot(~key_row_l));

endmodule

// ==== logic/pokey_cfg_pkg.sv ====
package pokey_cfg_pkg;

    // board clocks per o2 tick
    // 8 keeps simulation short, the board build runs 1800 for a 15 kHz scan rate
    localparam int O2_DIV = 8;
    localparam int O2_CNT_W = $clog2(O2_DIV);

    // keypad matrix
    // rows are strobed low one at a time and columns read back active low
    localparam int KEY_ROWS = 4;
    localparam int KEY_COLS = 3;
    localparam int KEY_ROW_W = $clog2(KEY_ROWS);
    localparam int KEY_COL_W = $clog2(KEY_COLS);

    // key code is row * KEY_COLS + column
    localparam int KEY_CODE_W = 4;

    // paddle counter width and the count that ends a scan
    localparam int POT_W = 8;
    localparam int POT_MAX = 228;

    // o2 ticks spent with the pot capacitors shorted
    localparam int POT_DUMP_TICKS = 2;
    localparam int NUM_POTS = 2;

    // joystick trigger buttons, active low
    localparam int NUM_TRIG = 4;

endpackage

// ==== logic/pokey_ports_top.sv ====
`timescale 1ns/1ns

module pokey_ports_top (
    input  logic                                 clk_27mhz_fpga,
    input  logic                                 rst,
    // keypad matrix
    input  logic [pokey_cfg_pkg::KEY_COLS-1:0]   key_col_l,
    output logic [pokey_cfg_pkg::KEY_ROWS-1:0]   key_row_l,
    output logic [pokey_cfg_pkg::KEY_CODE_W-1:0] kbcode,
    output logic                                 key_depr,
    // paddles
    input  logic [pokey_cfg_pkg::NUM_POTS-1:0]   pot_in,
    input  logic                                 potgo_req,
    output logic                                 potgo_ack,
    output logic [pokey_cfg_pkg::NUM_POTS-1:0]   pot_rel,
    output logic [pokey_cfg_pkg::POT_W-1:0]      pot0,
    output logic [pokey_cfg_pkg::POT_W-1:0]      pot1,
    output logic [pokey_cfg_pkg::POT_W-1:0]      allpot,
    // triggers
    input  logic [pokey_cfg_pkg::NUM_TRIG-1:0]   trig_l,
    input  logic                                 grac_latch,
    output logic [pokey_cfg_pkg::NUM_TRIG-1:0]   trig
);

    // o2 rate strobe shared by both scanners
    logic o2_tick;

    scan_timebase u_timebase (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst            (rst),
        .o2_tick        (o2_tick)
    );

    key_scanner u_key_scanner (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst            (rst),
        .o2_tick        (o2_tick),
        .key_col_l      (key_col_l),
        .key_row_l      (key_row_l),
        .kbcode         (kbcode),
        .key_depr       (key_depr)
    );

    pot_scanner u_pot_scanner (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst            (rst),
        .o2_tick        (o2_tick),
        .potgo_req      (potgo_req),
        .pot_in         (pot_in),
        .potgo_ack      (potgo_ack),
        .pot_rel        (pot_rel),
        .pot0           (pot0),
        .pot1           (pot1),
        .allpot         (allpot)
    );

    // triggers run on the board clock, no o2 needed
    trigger_latch u_trigger_latch (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst            (rst),
        .trig_l         (trig_l),
        .grac_latch     (grac_latch),
        .trig           (trig)
    );

endmodule

// ==== logic/pokey_state_pkg.sv ====
package pokey_state_pkg;

    // keypad compare-latch sequencer
    // confirm means one scan has seen a key
    // held means two scans in a row agreed on it
    typedef enum logic [1:0] {
        KEY_IDLE,
        KEY_CONFIRM,
        KEY_HELD
    } key_state_e;

    // paddle measurement sequencer
    // done holds ack until the host drops potgo
    typedef enum logic [1:0] {
        POT_IDLE,
        POT_DUMP,
        POT_COUNT,
        POT_DONE
    } pot_state_e;

endpackage

// ==== logic/pot_scanner.sv ====
`timescale 1ns/1ns

module pot_scanner (
    input  logic                               clk_27mhz_fpga,
    input  logic                               rst,
    input  logic                               o2_tick,
    input  logic                               potgo_req,
    input  logic [pokey_cfg_pkg::NUM_POTS-1:0] pot_in,
    output logic                               potgo_ack,
    output logic [pokey_cfg_pkg::NUM_POTS-1:0] pot_rel,
    output logic [pokey_cfg_pkg::POT_W-1:0]    pot0,
    output logic [pokey_cfg_pkg::POT_W-1:0]    pot1,
    output logic [pokey_cfg_pkg::POT_W-1:0]    allpot
);

    pokey_state_pkg::pot_state_e state;

    // comparator outputs are asynchronous
    logic [pokey_cfg_pkg::NUM_POTS-1:0] pot_meta;
    logic [pokey_cfg_pkg::NUM_POTS-1:0] pot_sync;

    logic req_q;
    logic go_pend;

    // dump tick counter, then the pot count
    logic [pokey_cfg_pkg::POT_W-1:0] bin_ctr;
    logic                            dump_last;
    logic                            count_last;

    // allpot bits, high while a pot is still charging
    logic [pokey_cfg_pkg::NUM_POTS-1:0] pot_pend;
    logic [pokey_cfg_pkg::POT_W-1:0]    pot_val [pokey_cfg_pkg::NUM_POTS];

    always_ff @(posedge clk_27mhz_fpga) begin
        pot_meta <= pot_in;
        pot_sync <= pot_meta;
    end

    // potgo rising edge waits here until the sequencer is idle
    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            req_q   <= 1'b0;
            go_pend <= 1'b0;
        end else begin
            req_q <= potgo_req;
            if (potgo_req && !req_q) begin
                go_pend <= 1'b1;
            end else if (state == pokey_state_pkg::POT_IDLE) begin
                go_pend <= 1'b0;
            end
        end
    end

    assign dump_last  = (bin_ctr == pokey_cfg_pkg::POT_W'(pokey_cfg_pkg::POT_DUMP_TICKS - 1));
    assign count_last = (bin_ctr == pokey_cfg_pkg::POT_W'(pokey_cfg_pkg::POT_MAX));

    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            state     <= pokey_state_pkg::POT_IDLE;
            bin_ctr   <= '0;
            potgo_ack <= 1'b0;
            pot_pend  <= '0;
            for (int i = 0; i < pokey_cfg_pkg::NUM_POTS; i++) begin
                pot_val[i] <= '0;
            end
        end else begin
            case (state)
                pokey_state_pkg::POT_IDLE: begin
                    if (go_pend) begin
                        state    <= pokey_state_pkg::POT_DUMP;
                        bin_ctr  <= '0;
                        pot_pend <= '1;
                    end
                end
                pokey_state_pkg::POT_DUMP: begin
                    if (o2_tick && dump_last) begin
                        state   <= pokey_state_pkg::POT_COUNT;
                        bin_ctr <= '0;
                    end else if (o2_tick) begin
                        bin_ctr <= bin_ctr + 1'b1;
                    end
                end
                pokey_state_pkg::POT_COUNT: begin
                    // a pot still pending at the last count gets POT_MAX
                    for (int i = 0; i < pokey_cfg_pkg::NUM_POTS; i++) begin
                        if (pot_pend[i] && (pot_sync[i] || (o2_tick && count_last))) begin
                            pot_val[i]  <= bin_ctr;
                            pot_pend[i] <= 1'b0;
                        end
                    end
                    if (o2_tick && count_last) begin
                        state     <= pokey_state_pkg::POT_DONE;
                        potgo_ack <= 1'b1;
                    end else if (o2_tick) begin
                        bin_ctr <= bin_ctr + 1'b1;
                    end
                end
                pokey_state_pkg::POT_DONE: begin
                    if (!potgo_req) begin
                        state     <= pokey_state_pkg::POT_IDLE;
                        potgo_ack <= 1'b0;
                    end
                end
                default: begin
                    state <= pokey_state_pkg::POT_IDLE;
                end
            endcase
        end
    end

    // release lags the state by one clock
    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            pot_rel <= '0;
        end else begin
            pot_rel <= {pokey_cfg_pkg::NUM_POTS{state == pokey_state_pkg::POT_DUMP}};
        end
    end

    assign pot0   = pot_val[0];
    assign pot1   = pot_val[1];
    assign allpot = {{(pokey_cfg_pkg::POT_W - pokey_cfg_pkg::NUM_POTS){1'b0}}, pot_pend};

    a_ack_no_rel: assert property (@(posedge clk_27mhz_fpga) disable iff (rst)
        potgo_ack |-> (pot_rel == '0));

    // ack holds for as long as the host keeps req up
    a_ack_holds: assert property (@(posedge clk_27mhz_fpga) disable iff (rst)
        potgo_ack && potgo_req |=> potgo_ack);

endmodule

// ==== logic/scan_timebase.sv ====
`timescale 1ns/1ns

module scan_timebase (
    input  logic clk_27mhz_fpga,
    input  logic rst,
    output logic o2_tick
);

    // down-counter, terminal count at zero
    logic [pokey_cfg_pkg::O2_CNT_W-1:0] div_cnt;

    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            div_cnt <= pokey_cfg_pkg::O2_CNT_W'(pokey_cfg_pkg::O2_DIV - 1);
            o2_tick <= 1'b0;
        end else begin
            // registered pulse, first one lands O2_DIV clocks after reset
            o2_tick <= (div_cnt == '0);
            if (div_cnt == '0) begin
                div_cnt <= pokey_cfg_pkg::O2_CNT_W'(pokey_cfg_pkg::O2_DIV - 1);
            end else begin
                div_cnt <= div_cnt - 1'b1;
            end
        end
    end

    // tick is a single clock wide, the scanners count on that
    a_tick_single: assert property (@(posedge clk_27mhz_fpga) disable iff (rst)
        o2_tick |=> !o2_tick);

endmodule

// ==== logic/trigger_latch.sv ====
`timescale 1ns/1ns

module trigger_latch (
    input  logic                               clk_27mhz_fpga,
    input  logic                               rst,
    input  logic [pokey_cfg_pkg::NUM_TRIG-1:0] trig_l,
    input  logic                               grac_latch,
    output logic [pokey_cfg_pkg::NUM_TRIG-1:0] trig
);

    // two flop synchronizer per button
    logic [pokey_cfg_pkg::NUM_TRIG-1:0] trig_meta;
    logic [pokey_cfg_pkg::NUM_TRIG-1:0] trig_sync;

    always_ff @(posedge clk_27mhz_fpga) begin
        if (rst) begin
            trig_meta <= '1;
            trig_sync <= '1;
            trig      <= '1;
        end else begin
            trig_meta <= trig_l;
            trig_sync <= trig_meta;
            // GRACTL bit 2 set, a press sticks until the bit clears
            if (grac_latch) begin
                trig <= trig & trig_sync;
            end else begin
                trig <= trig_sync;
            end
        end
    end

endmodule

// ==== verification/pokey_ports_checker.sv ====
`timescale 1ns/1ns

module pokey_ports_checker (
    input  logic                                 clk_27mhz_fpga,
    input  logic                                 rst,
    input  logic [pokey_cfg_pkg::KEY_ROWS-1:0]   key_row_l,
    input  logic [pokey_cfg_pkg::KEY_CODE_W-1:0] kbcode,
    input  logic                                 key_depr,
    input  logic                                 key_held,
    input  logic [pokey_cfg_pkg::KEY_CODE_W-1:0] key_exp,
    input  logic                                 potgo_req,
    input  logic                                 potgo_ack,
    input  logic [pokey_cfg_pkg::NUM_POTS-1:0]   pot_in,
    input  logic [pokey_cfg_pkg::NUM_POTS-1:0]   pot_rel,
    input  logic [pokey_cfg_pkg::POT_W-1:0]      pot0,
    input  logic [pokey_cfg_pkg::POT_W-1:0]      pot1,
    input  logic [pokey_cfg_pkg::POT_W-1:0]      allpot,
    input  int                                   delay0,
    input  int                                   delay1,
    input  logic [pokey_cfg_pkg::NUM_TRIG-1:0]   trig_l,
    input  logic                                 grac_latch,
    input  logic [pokey_cfg_pkg::NUM_TRIG-1:0]   trig,
    output int                                   err_count
);

    localparam int SCAN_CLKS = pokey_cfg_pkg::KEY_ROWS * pokey_cfg_pkg::O2_DIV;
    // slack covers the keypad model and the column synchronizer
    localparam int PRESS_LIMIT = 4 * SCAN_CLKS + 4;
    localparam int RELEASE_LIMIT = 2 * SCAN_CLKS + 4;

    // keypad tracking
    logic held_q = 1'b0;
    int   key_age = 0;
    logic key_flagged = 1'b0;

    // potgo handshake tracking
    logic req_q = 1'b0;
    logic ack_q = 1'b0;
    logic rel_q = 1'b0;
    logic armed = 1'b0;
    logic counting = 1'b0;
    int   req_age = 0;

    // trig_l as seen one, two and three clocks back
    logic [pokey_cfg_pkg::NUM_TRIG-1:0] tl_d1 = '1;
    logic [pokey_cfg_pkg::NUM_TRIG-1:0] tl_d2 = '1;
    logic [pokey_cfg_pkg::NUM_TRIG-1:0] tl_d3 = '1;
    logic [pokey_cfg_pkg::NUM_TRIG-1:0] trig_model = '1;
    logic [pokey_cfg_pkg::NUM_TRIG-1:0] exp_trig;
    logic                               grac_q = 1'b0;

    initial err_count = 0;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_count++;
        $display("error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_fail(input string what);
        err_count++;
        $display("failure: %s at %0t", what, $time);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    // count is charge time in ticks, saturating at the end of scan count
    task automatic check_pot(input string name, input logic [31:0] got, input int delay);
        int e;
        e = delay / pokey_cfg_pkg::O2_DIV;
        if (e > pokey_cfg_pkg::POT_MAX) begin
            expect_eq(name, got, pokey_cfg_pkg::POT_MAX);
        end else if ((int'(got) < e - 1) || (int'(got) > e + 1)) begin
            report_mismatch(name, got, e);
        end
    endtask

    // reset values, then the trigger pipeline
    always @(negedge clk_27mhz_fpga) begin
        if (rst) begin
            expect_eq("key_row_l", key_row_l, {{(pokey_cfg_pkg::KEY_ROWS - 1){1'b1}}, 1'b0});
            expect_eq("key_depr", key_depr, 0);
            expect_eq("kbcode", kbcode, 0);
            expect_eq("potgo_ack", potgo_ack, 0);
            expect_eq("pot_rel", pot_rel, 0);
            expect_eq("pot0", pot0, 0);
            expect_eq("pot1", pot1, 0);
            expect_eq("allpot", allpot, 0);
            expect_eq("trig", trig, {pokey_cfg_pkg::NUM_TRIG{1'b1}});
            trig_model = '1;
        end else begin
            // trig follows trig_l three clocks on, a latched low bit sticks
            exp_trig = grac_q ? (trig_model & tl_d3) : tl_d3;
            expect_eq("trig", trig, exp_trig);
            trig_model = exp_trig;
        end
        tl_d3 = tl_d2;
        tl_d2 = tl_d1;
        tl_d1 = trig_l;
        grac_q = grac_latch;
    end

    // keypad latency and code, one report per press or release
    always @(negedge clk_27mhz_fpga) begin
        if (key_held !== held_q) begin
            key_age = 0;
            key_flagged = 1'b0;
        end else begin
            key_age++;
        end
        held_q = key_held;
        if (!rst && !key_flagged) begin
            if (key_held && key_depr && (kbcode !== key_exp)) begin
                report_mismatch("kbcode", kbcode, key_exp);
                key_flagged = 1'b1;
            end else if (key_held && !key_depr && (key_age > PRESS_LIMIT)) begin
                report_fail("key_depr stayed low for more than 4 scans of a held key");
                key_flagged = 1'b1;
            end else if (!key_held && key_depr && (key_age > RELEASE_LIMIT)) begin
                report_fail("key_depr stayed high for more than 2 scans after release");
                key_flagged = 1'b1;
            end
        end
    end

    // potgo handshake, dump timing and pot results
    always @(negedge clk_27mhz_fpga) begin
        if (potgo_req && !req_q) begin
            req_age = 0;
            armed = 1'b1;
        end else begin
            req_age++;
        end
        if (!rst) begin
            expect_eq("allpot", allpot[pokey_cfg_pkg::POT_W-1:pokey_cfg_pkg::NUM_POTS], 0);
            if (pot_rel[0] && !rel_q) begin
                if (!armed) begin
                    report_fail("pot_rel rose with no new potgo request, a scan restarted");
                end else begin
                    expect_eq("pot_rel rise delay", req_age, 3);
                end
                armed = 1'b0;
            end
            if (!pot_rel[0] && rel_q) begin
                counting = 1'b1;
                expect_eq("allpot", allpot[pokey_cfg_pkg::NUM_POTS-1:0], 2'b11);
            end
            if (potgo_ack && (pot_rel !== '0)) begin
                report_fail("pot_rel is high while potgo_ack is high");
            end
            // a pot still charging keeps its allpot bit
            if (counting && !potgo_ack) begin
                for (int i = 0; i < pokey_cfg_pkg::NUM_POTS; i++) begin
                    if (!pot_in[i] && !allpot[i]) begin
                        report_fail("allpot bit cleared before its pot input rose");
                    end
                end
            end
            if (potgo_ack && !ack_q) begin
                counting = 1'b0;
                expect_eq("allpot", allpot, 0);
                check_pot("pot0", pot0, delay0);
                check_pot("pot1", pot1, delay1);
            end
            if (!potgo_ack && ack_q && req_q) begin
                report_fail("potgo_ack fell while potgo_req was still high");
            end
        end
        req_q = potgo_req;
        ack_q = potgo_ack;
        rel_q = pot_rel[0];
    end

endmodule

// ==== verification/pokey_ports_tb.sv ====
`timescale 1ns/1ns

module pokey_ports_tb;

    localparam int SCAN_CLKS = pokey_cfg_pkg::KEY_ROWS * pokey_cfg_pkg::O2_DIV;

    logic                                 clk_27mhz_fpga = 1'b0;
    logic                                 rst = 1'b1;
    logic [pokey_cfg_pkg::KEY_COLS-1:0]   key_col_l = '1;
    logic [pokey_cfg_pkg::NUM_POTS-1:0]   pot_in = '0;
    logic                                 potgo_req = 1'b0;
    logic [pokey_cfg_pkg::NUM_TRIG-1:0]   trig_l = '1;
    logic                                 grac_latch = 1'b0;
    logic [pokey_cfg_pkg::KEY_ROWS-1:0]   key_row_l;
    logic [pokey_cfg_pkg::KEY_CODE_W-1:0] kbcode;
    logic                                 key_depr;
    logic                                 potgo_ack;
    logic [pokey_cfg_pkg::NUM_POTS-1:0]   pot_rel;
    logic [pokey_cfg_pkg::POT_W-1:0]      pot0;
    logic [pokey_cfg_pkg::POT_W-1:0]      pot1;
    logic [pokey_cfg_pkg::POT_W-1:0]      allpot;
    logic [pokey_cfg_pkg::NUM_TRIG-1:0]   trig;

    // keypad model state
    logic                                 key_held = 1'b0;
    logic [pokey_cfg_pkg::KEY_CODE_W-1:0] key_exp = '0;
    int                                   key_row = 0;
    int                                   key_col = 0;

    // pot model, charge delay in clocks per paddle
    int pot_delay [pokey_cfg_pkg::NUM_POTS] = '{1, 1};
    int pot_cnt [pokey_cfg_pkg::NUM_POTS] = '{0, 0};

    logic [31:0] lcg_state = 32'heec6_9d0c;
    int          timeouts = 0;
    int          err_count;

    always #10 clk_27mhz_fpga = ~clk_27mhz_fpga;

    pokey_ports_top DUT (.*);

    pokey_ports_checker chk (
        .delay0 (pot_delay[0]),
        .delay1 (pot_delay[1]),
        .*
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pick(input int n, output int v);
        lcg_state = lcg_step(lcg_state);
        v = int'(lcg_state[31:8] % n);
    endtask

    // column pulled low while the held key's row is strobed
    always @(posedge clk_27mhz_fpga) begin
        if (key_held && !key_row_l[key_row]) begin
            key_col_l <= ~(pokey_cfg_pkg::KEY_COLS'(1) << key_col);
        end else begin
            key_col_l <= '1;
        end
    end

    // capacitor shorted while released, charges D clocks after release falls
    always @(posedge clk_27mhz_fpga) begin
        for (int i = 0; i < pokey_cfg_pkg::NUM_POTS; i++) begin
            if (pot_rel[i]) begin
                pot_cnt[i] <= 0;
                pot_in[i]  <= 1'b0;
            end else if (pot_cnt[i] >= pot_delay[i]) begin
                pot_in[i] <= 1'b1;
            end else begin
                pot_cnt[i] <= pot_cnt[i] + 1;
            end
        end
    end

    task automatic wait_key_depr(input logic level, input int limit);
        int n;
        n = 0;
        while ((key_depr !== level) && (n < limit)) begin
            @(negedge clk_27mhz_fpga);
            n++;
        end
        if (key_depr !== level) begin
            $display("timeout waiting for key_depr to become %0d", level);
            timeouts++;
        end
    endtask

    task automatic wait_potgo_ack(input logic level, input int limit);
        int n;
        n = 0;
        while ((potgo_ack !== level) && (n < limit)) begin
            @(negedge clk_27mhz_fpga);
            n++;
        end
        if (potgo_ack !== level) begin
            $display("timeout waiting for potgo_ack to become %0d", level);
            timeouts++;
        end
    endtask

    task automatic run_keys();
        int row;
        int col;
        int extra;
        repeat (5) begin
            pick(pokey_cfg_pkg::KEY_ROWS, row);
            pick(pokey_cfg_pkg::KEY_COLS, col);
            @(posedge clk_27mhz_fpga);
            key_row  <= row;
            key_col  <= col;
            key_exp  <= pokey_cfg_pkg::KEY_CODE_W'(row * pokey_cfg_pkg::KEY_COLS + col);
            key_held <= 1'b1;
            wait_key_depr(1'b1, 6 * SCAN_CLKS);
            // keep it down a little longer
            pick(3, extra);
            repeat (extra * SCAN_CLKS + 1) @(posedge clk_27mhz_fpga);
            key_held <= 1'b0;
            wait_key_depr(1'b0, 4 * SCAN_CLKS);
            pick(40, extra);
            repeat (extra + 8) @(posedge clk_27mhz_fpga);
        end
    endtask

    task automatic run_pots();
        int d0;
        int d1;
        int hold;
        for (int s = 0; s < 4; s++) begin
            pick(1900, d0);
            pick(1900, d1);
            // last scan has pot 0 run past the end of count
            if (s == 3) begin
                d0 = 1840 + d0 % 100;
            end
            @(posedge clk_27mhz_fpga);
            pot_delay[0] <= d0 + 1;
            pot_delay[1] <= d1 + 1;
            potgo_req    <= 1'b1;
            wait_potgo_ack(1'b1, 2400);
            // request held past ack must not restart the scan
            pick(64, hold);
            repeat (hold + 16) @(posedge clk_27mhz_fpga);
            potgo_req <= 1'b0;
            wait_potgo_ack(1'b0, 16);
            repeat (8) @(posedge clk_27mhz_fpga);
        end
    endtask

    task automatic run_triggers();
        int a;
        int b;
        repeat (40) begin
            pick(16, a);
            @(posedge clk_27mhz_fpga);
            trig_l <= pokey_cfg_pkg::NUM_TRIG'(a);
        end
        @(posedge clk_27mhz_fpga);
        trig_l <= '1;
        repeat (4) @(posedge clk_27mhz_fpga);
        grac_latch <= 1'b1;
        // buttons mostly released so latching is visible bit by bit
        repeat (40) begin
            pick(16, a);
            pick(16, b);
            @(posedge clk_27mhz_fpga);
            trig_l <= pokey_cfg_pkg::NUM_TRIG'(a | b);
        end
        @(posedge clk_27mhz_fpga);
        grac_latch <= 1'b0;
        repeat (8) @(posedge clk_27mhz_fpga);
        trig_l <= '1;
    endtask

    initial begin
        repeat (5) @(posedge clk_27mhz_fpga);
        rst <= 1'b0;
        repeat (4) @(posedge clk_27mhz_fpga);
        run_keys();
        run_pots();
        run_triggers();
        repeat (8) @(posedge clk_27mhz_fpga);
        $display("run complete: %0d errors, %0d timeouts", err_count, timeouts);
        if ((err_count == 0) && (timeouts == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/pokey_cfg_pkg.sv
logic/pokey_state_pkg.sv
logic/scan_timebase.sv
logic/key_scanner.sv
logic/pot_scanner.sv
logic/trigger_latch.sv
logic/pokey_ports_top.sv
verification/pokey_ports_checker.sv
verification/pokey_ports_tb.sv
